// File: Makefile
RTL = design/rv_ex_pkg.sv design/rv_ex_decode.sv design/rv_ex_alu.sv \
      design/rv_ex_csr_file.sv design/rv_ex_top.sv

.PHONY: all lint clean

all:
	verilator --binary -j 0 --assert -f rv_ex.f --top-module rv_ex_tb
	@out="$$(./obj_dir/Vrv_ex_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only --top-module rv_ex_top $(RTL)

clean:
	rm -rf obj_dir

// File: design/rv_ex_alu.sv
/*
  ALU stage. One cycle from ex_req_t to result and CSR write.
  CSR read is combinational from the CSR file; there is no forwarding, so
  a CSR read right behind a write to the same CSR sees the old value.
  flush_i kills the item being loaded, even under stall.
*/
`timescale 1ns/1ps

module rv_ex_alu #(
  parameter int XLEN = 32
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                stall_i,
  input  logic                flush_i,
  input  rv_ex_pkg::ex_req_t  req_i,
  input  logic [XLEN-1:0]     csr_rval_i,
  output logic [11:0]         csr_raddr_o,
  output rv_ex_pkg::wb_res_t  res_o,
  output logic                csr_we_o,
  output logic [11:0]         csr_addr_o,
  output logic [XLEN-1:0]     csr_wval_o
);

  localparam int SBITS = $clog2(XLEN);

  logic [XLEN-1:0]  opa;
  logic [XLEN-1:0]  opb;
  logic [XLEN-1:0]  pc;
  logic [SBITS-1:0] shamt;
  logic [XLEN-1:0]  result_d;
  logic [XLEN-1:0]  csr_wval_d;
  logic             bubble_d;
  logic             csr_we_d;

  // Stage registers
  logic             bubble_q;
  logic [4:0]       rd_q;
  logic [XLEN-1:0]  result_q;
  logic             csr_we_q;
  logic [11:0]      csr_addr_q;
  logic [XLEN-1:0]  csr_wval_q;

  assign opa   = req_i.opa[XLEN-1:0];
  assign opb   = req_i.opb[XLEN-1:0];
  assign pc    = req_i.pc[XLEN-1:0];
  assign shamt = opb[SBITS-1:0];

  // CSR file read port
  assign csr_raddr_o = req_i.csr_addr;

  //////////////////////////////
  // Result
  //////////////////////////////

  always_comb begin
    case (req_i.op)
      // LUI has opa zero, AUIPC has opa pc
      rv_ex_pkg::OP_LUI,
      rv_ex_pkg::OP_AUIPC,
      rv_ex_pkg::OP_ADD:   result_d = opa + opb;
      rv_ex_pkg::OP_SUB:   result_d = opa - opb;
      // Link address, no compressed instructions
      rv_ex_pkg::OP_JAL,
      rv_ex_pkg::OP_JALR:  result_d = pc + XLEN'(4);
      rv_ex_pkg::OP_XOR:   result_d = opa ^ opb;
      rv_ex_pkg::OP_OR:    result_d = opa | opb;
      rv_ex_pkg::OP_AND:   result_d = opa & opb;
      rv_ex_pkg::OP_SLL:   result_d = opa << shamt;
      rv_ex_pkg::OP_SRL:   result_d = opa >> shamt;
      rv_ex_pkg::OP_SRA:   result_d = $signed(opa) >>> shamt;
      rv_ex_pkg::OP_SLT:   result_d = XLEN'($signed(opa) < $signed(opb));
      rv_ex_pkg::OP_SLTU:  result_d = XLEN'(opa < opb);
      // CSR ops return the old value
      rv_ex_pkg::OP_CSRRW,
      rv_ex_pkg::OP_CSRRS,
      rv_ex_pkg::OP_CSRRC: result_d = csr_rval_i;
      default:             result_d = '0;
    endcase
  end

  //////////////////////////////
  // CSR write value
  //////////////////////////////

  always_comb begin
    case (req_i.op)
      rv_ex_pkg::OP_CSRRS: csr_wval_d = csr_rval_i | opa;
      rv_ex_pkg::OP_CSRRC: csr_wval_d = csr_rval_i & ~opa;
      // CSRRW and everything else
      default:             csr_wval_d = opa;
    endcase
  end

  // Flush and unknown ops turn into bubbles
  assign bubble_d = req_i.bubble || flush_i || (req_i.op == rv_ex_pkg::OP_NONE);

  // Single pulse per instruction, held off while stalled
  assign csr_we_d = req_i.csr_wr_req && !bubble_d && !stall_i;

  //////////////////////////////
  // Stage registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bubble_q <= 1'b1;
    end else if (flush_i) begin
      bubble_q <= 1'b1;
    end else if (!stall_i) begin
      bubble_q <= bubble_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_we_q <= 1'b0;
    end else begin
      csr_we_q <= csr_we_d;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      rd_q       <= req_i.rd;
      result_q   <= result_d;
      csr_addr_q <= req_i.csr_addr;
      csr_wval_q <= csr_wval_d;
    end
  end

  assign res_o.bubble = bubble_q;
  assign res_o.rd     = rd_q;
  assign res_o.result = 64'(result_q);
  assign csr_we_o     = csr_we_q;
  assign csr_addr_o   = csr_addr_q;
  assign csr_wval_o   = csr_wval_q;

endmodule

// File: design/rv_ex_csr_file.sv
/*
  Scratch CSR file, CSR_SCRATCH_NUM read/write registers from
  CSR_SCRATCH_BASE up. Other addresses read zero and drop writes.
  No privilege or read-only checks.
*/
`timescale 1ns/1ps

module rv_ex_csr_file #(
  parameter int XLEN = 32
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [11:0]     raddr_i,
  input  logic            we_i,
  input  logic [11:0]     waddr_i,
  input  logic [XLEN-1:0] wval_i,
  output logic [XLEN-1:0] rval_o
);

  localparam int IDX_W = $clog2(rv_ex_pkg::CSR_SCRATCH_NUM);

  logic [XLEN-1:0] scratch_q [rv_ex_pkg::CSR_SCRATCH_NUM];
  logic [11:0]     roff;
  logic [11:0]     woff;
  logic            rhit;
  logic            whit;

  // Offsets into the scratch window, wrap makes low addresses miss
  assign roff = raddr_i - rv_ex_pkg::CSR_SCRATCH_BASE;
  assign woff = waddr_i - rv_ex_pkg::CSR_SCRATCH_BASE;
  assign rhit = roff < 12'(rv_ex_pkg::CSR_SCRATCH_NUM);
  assign whit = woff < 12'(rv_ex_pkg::CSR_SCRATCH_NUM);

  // Combinational read
  assign rval_o = rhit ? scratch_q[roff[IDX_W-1:0]] : '0;

  // Clocked write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < rv_ex_pkg::CSR_SCRATCH_NUM; i++) begin
        scratch_q[i] <= '0;
      end
    end else if (we_i && whit) begin
      scratch_q[woff[IDX_W-1:0]] <= wval_i;
    end
  end

endmodule

// File: design/rv_ex_decode.sv
/*
  Decode stage. Registers one ex_req_t per cycle unless stalled.
  Only RV32I/RV64I ALU, jump-link and Zicsr encodings are known; others
  come out as OP_NONE bubbles. RV64 W forms are not decoded.
*/
`timescale 1ns/1ps

module rv_ex_decode #(
  parameter int XLEN = 32
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                stall_i,
  input  logic [31:0]         insn_i,
  input  logic                insn_valid_i,
  input  logic [XLEN-1:0]     pc_i,
  input  logic [XLEN-1:0]     rs1_val_i,
  input  logic [XLEN-1:0]     rs2_val_i,
  output rv_ex_pkg::ex_req_t  req_o
);

  // Major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_u;
  logic [XLEN-1:0]     zimm;
  logic                shift_ok;
  rv_ex_pkg::alu_op_t  op;
  logic [XLEN-1:0]     opa;
  logic [XLEN-1:0]     opb;
  logic                csr_wr_req;
  rv_ex_pkg::ex_req_t  req_d;
  rv_ex_pkg::ex_req_t  req_q;

  //////////////////////////////
  // Fields and immediates
  //////////////////////////////

  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];
  // Sign extended I and U immediates
  assign imm_i  = XLEN'($signed(insn_i[31:20]));
  assign imm_u  = XLEN'($signed({insn_i[31:12], 12'b0}));
  // Zero extended CSR immediate
  assign zimm   = XLEN'(insn_i[19:15]);

  // Shift immediate, shamt[5] only legal on RV64
  assign shift_ok = !insn_i[31] && (insn_i[29:26] == 4'b0) && (XLEN == 64 || !insn_i[25]);

  //////////////////////////////
  // Opcode and operand select
  //////////////////////////////

  always_comb begin
    op  = rv_ex_pkg::OP_NONE;
    opa = rs1_val_i;
    opb = rs2_val_i;
    case (insn_i[6:0])
      OPC_LUI: begin
        op  = rv_ex_pkg::OP_LUI;
        opa = '0;
        opb = imm_u;
      end
      OPC_AUIPC: begin
        op  = rv_ex_pkg::OP_AUIPC;
        opa = pc_i;
        opb = imm_u;
      end
      // Link result only, target is computed elsewhere
      OPC_JAL: begin
        op  = rv_ex_pkg::OP_JAL;
        opa = pc_i;
        opb = '0;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) op = rv_ex_pkg::OP_JALR;
        opb = imm_i;
      end
      OPC_OPIMM: begin
        opb = imm_i;
        case (funct3)
          3'b000: op = rv_ex_pkg::OP_ADD;
          3'b010: op = rv_ex_pkg::OP_SLT;
          3'b011: op = rv_ex_pkg::OP_SLTU;
          3'b100: op = rv_ex_pkg::OP_XOR;
          3'b110: op = rv_ex_pkg::OP_OR;
          3'b111: op = rv_ex_pkg::OP_AND;
          3'b001: if (shift_ok && !insn_i[30]) op = rv_ex_pkg::OP_SLL;
          default: begin
            // srli and srai share funct3, bit 30 picks arithmetic
            if (shift_ok) op = insn_i[30] ? rv_ex_pkg::OP_SRA : rv_ex_pkg::OP_SRL;
          end
        endcase
      end
      OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: op = rv_ex_pkg::OP_ADD;
          10'b0100000_000: op = rv_ex_pkg::OP_SUB;
          10'b0000000_001: op = rv_ex_pkg::OP_SLL;
          10'b0000000_010: op = rv_ex_pkg::OP_SLT;
          10'b0000000_011: op = rv_ex_pkg::OP_SLTU;
          10'b0000000_100: op = rv_ex_pkg::OP_XOR;
          10'b0000000_101: op = rv_ex_pkg::OP_SRL;
          10'b0100000_101: op = rv_ex_pkg::OP_SRA;
          10'b0000000_110: op = rv_ex_pkg::OP_OR;
          10'b0000000_111: op = rv_ex_pkg::OP_AND;
          default:         op = rv_ex_pkg::OP_NONE;
        endcase
      end
      OPC_SYSTEM: begin
        // funct3[2] selects the immediate forms
        opa = funct3[2] ? zimm : rs1_val_i;
        opb = '0;
        case (funct3[1:0])
          2'b01:   op = rv_ex_pkg::OP_CSRRW;
          2'b10:   op = rv_ex_pkg::OP_CSRRS;
          2'b11:   op = rv_ex_pkg::OP_CSRRC;
          // ecall, ebreak and friends
          default: op = rv_ex_pkg::OP_NONE;
        endcase
      end
      default: op = rv_ex_pkg::OP_NONE;
    endcase
  end

  // Set and clear forms write only with a nonzero mask
  always_comb begin
    case (op)
      rv_ex_pkg::OP_CSRRW: csr_wr_req = 1'b1;
      rv_ex_pkg::OP_CSRRS,
      rv_ex_pkg::OP_CSRRC: csr_wr_req = |opa;
      default:             csr_wr_req = 1'b0;
    endcase
  end

  //////////////////////////////
  // Stage register
  //////////////////////////////

  always_comb begin
    req_d.bubble     = !insn_valid_i || (op == rv_ex_pkg::OP_NONE);
    req_d.op         = op;
    req_d.rd         = insn_i[11:7];
    req_d.pc         = 64'(pc_i);
    req_d.opa        = 64'(opa);
    req_d.opb        = 64'(opb);
    req_d.csr_addr   = insn_i[31:20];
    req_d.csr_wr_req = csr_wr_req;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q        <= '0;
      req_q.bubble <= 1'b1;
      req_q.op     <= rv_ex_pkg::OP_NONE;
    end else if (!stall_i) begin
      req_q <= req_d;
    end
  end

  assign req_o = req_q;

endmodule

// File: design/rv_ex_pkg.sv
/*
  Shared types for the RISC-V execute slice.
  Struct payload fields are fixed at 64 bits; modules use the low XLEN bits.
  Register and immediate forms of an operation share one opcode.
*/
package rv_ex_pkg;

  //////////////////////////////
  // ALU opcodes
  //////////////////////////////

  typedef enum logic [4:0] {
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU,
    OP_CSRRW,
    OP_CSRRS,
    OP_CSRRC,
    // Unknown or unsupported encoding
    OP_NONE
  } alu_op_t;

  //////////////////////////////
  // Stage payloads
  //////////////////////////////

  // Decode to ALU
  typedef struct packed {
    logic        bubble;
    alu_op_t     op;
    logic [4:0]  rd;
    logic [63:0] pc;
    logic [63:0] opa;
    logic [63:0] opb;
    logic [11:0] csr_addr;
    // Set when the CSR instruction must write
    logic        csr_wr_req;
  } ex_req_t;

  // ALU writeback result
  typedef struct packed {
    logic        bubble;
    logic [4:0]  rd;
    logic [63:0] result;
  } wb_res_t;

  //////////////////////////////
  // CSR map
  //////////////////////////////

  // Scratch CSRs, mscratch and up
  localparam logic [11:0] CSR_SCRATCH_BASE = 12'h340;
  localparam int          CSR_SCRATCH_NUM  = 4;

endpackage

// File: design/rv_ex_top.sv
/*
  Execute slice top. Decode and ALU stages plus scratch CSR file.
  XLEN is 32 or 64. Two items in flight; stall_i freezes both stages.
*/
`timescale 1ns/1ps

module rv_ex_top #(
  parameter int XLEN = 32
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [31:0]         insn_i,
  input  logic                insn_valid_i,
  input  logic [XLEN-1:0]     pc_i,
  input  logic [XLEN-1:0]     rs1_val_i,
  input  logic [XLEN-1:0]     rs2_val_i,
  input  logic                stall_i,
  input  logic                flush_i,
  output rv_ex_pkg::wb_res_t  res_o,
  output logic                csr_we_o,
  output logic [11:0]         csr_addr_o,
  output logic [XLEN-1:0]     csr_wval_o
);

  rv_ex_pkg::ex_req_t req;
  logic [11:0]        csr_raddr;
  logic [XLEN-1:0]    csr_rval;

  //////////////////////////////
  // Decode stage
  //////////////////////////////

  rv_ex_decode #(
    .XLEN (XLEN)
  ) rv_ex_decode_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .pc_i         (pc_i),
    .rs1_val_i    (rs1_val_i),
    .rs2_val_i    (rs2_val_i),
    .req_o        (req)
  );

  //////////////////////////////
  // ALU stage
  //////////////////////////////

  rv_ex_alu #(
    .XLEN (XLEN)
  ) rv_ex_alu_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (stall_i),
    .flush_i     (flush_i),
    .req_i       (req),
    .csr_rval_i  (csr_rval),
    .csr_raddr_o (csr_raddr),
    .res_o       (res_o),
    .csr_we_o    (csr_we_o),
    .csr_addr_o  (csr_addr_o),
    .csr_wval_o  (csr_wval_o)
  );

  // Registered CSR write feeds back into the file
  rv_ex_csr_file #(
    .XLEN (XLEN)
  ) rv_ex_csr_file_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .raddr_i (csr_raddr),
    .we_i    (csr_we_o),
    .waddr_i (csr_addr_o),
    .wval_i  (csr_wval_o),
    .rval_o  (csr_rval)
  );

endmodule

// File: rv_ex.f
design/rv_ex_pkg.sv
design/rv_ex_decode.sv
design/rv_ex_alu.sv
design/rv_ex_csr_file.sv
design/rv_ex_top.sv
testbench/rv_ex_tb.sv

// File: testbench/rv_ex_tb.sv
/*
  Testbench for the execute slice at XLEN = 32.
  Entries run back to back; each is checked two unstalled edges after it is
  driven. The flush bit of an entry is raised while that entry loads the ALU.
*/
`timescale 1ns/1ps

module rv_ex_tb;

  localparam int XLEN = 32;

  // ISA major opcodes
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_SYS   = 7'b1110011;

  typedef struct packed {
    logic [31:0] insn;
    logic        valid;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        stall;
    logic        flush;
    logic        exp_bubble;
    logic [4:0]  exp_rd;
    logic [31:0] exp_result;
    logic        exp_we;
    logic [11:0] exp_caddr;
    logic [31:0] exp_cval;
  } test_t;

  logic               clk_i;
  logic               rst_ni;
  logic [31:0]        insn_i;
  logic               insn_valid_i;
  logic [XLEN-1:0]    pc_i;
  logic [XLEN-1:0]    rs1_val_i;
  logic [XLEN-1:0]    rs2_val_i;
  logic               stall_i;
  logic               flush_i;
  rv_ex_pkg::wb_res_t res;
  logic               csr_we_o;
  logic [11:0]        csr_addr_o;
  logic [XLEN-1:0]    csr_wval_o;

  test_t tests[$];
  string names[$];
  bit    test_bad[$];
  int    passes = 0;
  int    fails  = 0;
  int    cycles = 0;
  int    limit  = 0;

  rv_ex_top #(
    .XLEN (XLEN)
  ) rv_ex_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .pc_i         (pc_i),
    .rs1_val_i    (rs1_val_i),
    .rs2_val_i    (rs2_val_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .res_o        (res),
    .csr_we_o     (csr_we_o),
    .csr_addr_o   (csr_addr_o),
    .csr_wval_o   (csr_wval_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Encoders and table helpers
  //////////////////////////////

  // Register form, source fields unused since values come from the ports
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, 5'd2, 5'd1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1f,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1f, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  task automatic add_test(input string name, input logic [31:0] insn, input logic valid,
                          input logic [31:0] pc, input logic [31:0] rs1,
                          input logic [31:0] rs2, input logic stall, input logic flush,
                          input logic bubble, input logic [4:0] rd,
                          input logic [31:0] result, input logic we,
                          input logic [11:0] caddr, input logic [31:0] cval);
    test_t t;
    t = '{insn, valid, pc, rs1, rs2, stall, flush, bubble, rd, result, we, caddr, cval};
    tests.push_back(t);
    names.push_back(name);
    test_bad.push_back(1'b0);
  endtask

  task automatic report(input string name, input bit bad);
    if (bad) begin
      fails++;
      $display("FAIL %s", name);
    end else begin
      passes++;
      $display("PASS %s", name);
    end
  endtask

  // Entry i on the inputs; flush belongs to the entry now in decode
  task automatic apply_inputs(input int i, input logic stall);
    if (i < tests.size()) begin
      insn_i       = tests[i].insn;
      insn_valid_i = tests[i].valid;
      pc_i         = tests[i].pc;
      rs1_val_i    = tests[i].rs1;
      rs2_val_i    = tests[i].rs2;
    end else begin
      insn_i       = '0;
      insn_valid_i = 1'b0;
    end
    stall_i = stall;
    flush_i = (i >= 1 && i - 1 < tests.size()) ? tests[i-1].flush : 1'b0;
  endtask

  // Compare outputs with entry k; a held check expects no CSR write pulse
  task automatic check_outputs(input int k, input int owner, input bit held);
    test_t t;
    logic  exp_we;
    t = tests[k];
    exp_we = held ? 1'b0 : t.exp_we;
    assert (res.bubble == t.exp_bubble) else begin
      $display("FAILED %s bubble: expected %0h actual %0h", names[owner], t.exp_bubble,
               res.bubble);
      test_bad[owner] = 1'b1;
    end
    if (!t.exp_bubble) begin
      assert (res.rd == t.exp_rd) else begin
        $display("FAILED %s rd: expected %0d actual %0d", names[owner], t.exp_rd, res.rd);
        test_bad[owner] = 1'b1;
      end
      assert (res.result == 64'(t.exp_result)) else begin
        $display("FAILED %s result: expected %0h actual %0h", names[owner], t.exp_result,
                 res.result);
        test_bad[owner] = 1'b1;
      end
    end
    assert (csr_we_o == exp_we) else begin
      $display("FAILED %s csr_we: expected %0h actual %0h", names[owner], exp_we, csr_we_o);
      test_bad[owner] = 1'b1;
    end
    if (exp_we) begin
      assert (csr_addr_o == t.exp_caddr && csr_wval_o == t.exp_cval) else begin
        $display("FAILED %s csr write: expected %0h=%0h actual %0h=%0h", names[owner],
                 t.exp_caddr, t.exp_cval, csr_addr_o, csr_wval_o);
        test_bad[owner] = 1'b1;
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int i;
    bit reset_bad;
    reset_bad    = 1'b0;
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    pc_i         = '0;
    rs1_val_i    = '0;
    rs2_val_i    = '0;
    stall_i      = 1'b0;
    flush_i      = 1'b0;

    add_test("add", r_type(7'h00, 3'd0, 5'd1), 1'b1, 32'h0, 32'h1234, 32'h4321, 1'b0, 1'b0,
             1'b0, 5'd1, 32'h5555, 1'b0, 12'h0, 32'h0);
    add_test("addi_wrap", i_type(12'h001, 5'd1, 3'd0, 5'd2, OPC_IMM), 1'b1, 32'h0,
             32'hffffffff, 32'h0, 1'b0, 1'b0, 1'b0, 5'd2, 32'h0, 1'b0, 12'h0, 32'h0);
    add_test("sub", r_type(7'h20, 3'd0, 5'd3), 1'b1, 32'h0, 32'h5, 32'h7, 1'b0, 1'b0,
             1'b0, 5'd3, 32'hfffffffe, 1'b0, 12'h0, 32'h0);
    add_test("xor", r_type(7'h00, 3'd4, 5'd4), 1'b1, 32'h0, 32'hf0f0f0f0, 32'hff00ff00,
             1'b0, 1'b0, 1'b0, 5'd4, 32'h0ff00ff0, 1'b0, 12'h0, 32'h0);
    add_test("or", r_type(7'h00, 3'd6, 5'd5), 1'b1, 32'h0, 32'hf0f0f0f0, 32'h0f000000,
             1'b0, 1'b0, 1'b0, 5'd5, 32'hfff0f0f0, 1'b0, 12'h0, 32'h0);
    add_test("andi", i_type(12'hff0, 5'd1, 3'd7, 5'd6, OPC_IMM), 1'b1, 32'h0, 32'h12345678,
             32'h0, 1'b0, 1'b0, 1'b0, 5'd6, 32'h12345670, 1'b0, 12'h0, 32'h0);
    add_test("lui", u_type(20'h12345, 5'd7, OPC_LUI), 1'b1, 32'h0, 32'hdeadbeef, 32'h0,
             1'b0, 1'b0, 1'b0, 5'd7, 32'h12345000, 1'b0, 12'h0, 32'h0);
    add_test("auipc", u_type(20'h00001, 5'd8, OPC_AUIPC), 1'b1, 32'h100, 32'h0, 32'h0,
             1'b0, 1'b0, 1'b0, 5'd8, 32'h00001100, 1'b0, 12'h0, 32'h0);
    // Shift amount 36 keeps only its low 5 bits
    add_test("sll_amount", r_type(7'h00, 3'd1, 5'd9), 1'b1, 32'h0, 32'h80000001, 32'h24,
             1'b0, 1'b0, 1'b0, 5'd9, 32'h00000010, 1'b0, 12'h0, 32'h0);
    add_test("srl", r_type(7'h00, 3'd5, 5'd10), 1'b1, 32'h0, 32'h80000000, 32'h4, 1'b0,
             1'b0, 1'b0, 5'd10, 32'h08000000, 1'b0, 12'h0, 32'h0);
    add_test("sra", r_type(7'h20, 3'd5, 5'd11), 1'b1, 32'h0, 32'h80000000, 32'h4, 1'b0,
             1'b0, 1'b0, 5'd11, 32'hf8000000, 1'b0, 12'h0, 32'h0);
    add_test("srai", i_type(12'h408, 5'd1, 3'd5, 5'd12, OPC_IMM), 1'b1, 32'h0, 32'hffff0000,
             32'h0, 1'b0, 1'b0, 1'b0, 5'd12, 32'hffffff00, 1'b0, 12'h0, 32'h0);
    // Same operands, sign bits differ
    add_test("slt", r_type(7'h00, 3'd2, 5'd13), 1'b1, 32'h0, 32'hffffffff, 32'h1, 1'b0,
             1'b0, 1'b0, 5'd13, 32'h1, 1'b0, 12'h0, 32'h0);
    add_test("sltu", r_type(7'h00, 3'd3, 5'd14), 1'b1, 32'h0, 32'hffffffff, 32'h1, 1'b0,
             1'b0, 1'b0, 5'd14, 32'h0, 1'b0, 12'h0, 32'h0);
    add_test("jal", u_type(20'h00400, 5'd15, OPC_JAL), 1'b1, 32'h200, 32'h55, 32'haa, 1'b0,
             1'b0, 1'b0, 5'd15, 32'h204, 1'b0, 12'h0, 32'h0);
    add_test("jalr", i_type(12'h010, 5'd1, 3'd0, 5'd16, OPC_JALR), 1'b1, 32'h300, 32'h1000,
             32'h0, 1'b0, 1'b0, 1'b0, 5'd16, 32'h304, 1'b0, 12'h0, 32'h0);
    // First scratch CSR nonzero, so an aliased unmapped read would show it
    add_test("csrrw_base", i_type(12'h340, 5'd1, 3'd1, 5'd27, OPC_SYS), 1'b1, 32'h0, 32'h3c,
             32'h0, 1'b0, 1'b0, 1'b0, 5'd27, 32'h0, 1'b1, 12'h340, 32'h3c);
    add_test("csrrw", i_type(12'h341, 5'd1, 3'd1, 5'd17, OPC_SYS), 1'b1, 32'h0, 32'ha5,
             32'h0, 1'b0, 1'b0, 1'b0, 5'd17, 32'h0, 1'b1, 12'h341, 32'ha5);
    // Gap so the CSR write lands before the next read of 0x341
    add_test("invalid", i_type(12'h342, 5'd1, 3'd1, 5'd18, OPC_SYS), 1'b0, 32'h0, 32'h77,
             32'h0, 1'b0, 1'b0, 1'b1, 5'd18, 32'h0, 1'b0, 12'h0, 32'h0);
    add_test("csrrs", i_type(12'h341, 5'd1, 3'd2, 5'd19, OPC_SYS), 1'b1, 32'h0, 32'hf00,
             32'h0, 1'b0, 1'b0, 1'b0, 5'd19, 32'ha5, 1'b1, 12'h341, 32'hfa5);
    add_test("xori", i_type(12'hfff, 5'd1, 3'd4, 5'd20, OPC_IMM), 1'b1, 32'h0, 32'h0000ffff,
             32'h0, 1'b0, 1'b0, 1'b0, 5'd20, 32'hffff0000, 1'b0, 12'h0, 32'h0);
    add_test("stall_slti", i_type(12'h800, 5'd1, 3'd2, 5'd21, OPC_IMM), 1'b1, 32'h0,
             32'hfffff000, 32'h0, 1'b1, 1'b0, 1'b0, 5'd21, 32'h1, 1'b0, 12'h0, 32'h0);
    add_test("csrrc_zero", i_type(12'h341, 5'd1, 3'd3, 5'd22, OPC_SYS), 1'b1, 32'h0, 32'h0,
             32'h0, 1'b0, 1'b0, 1'b0, 5'd22, 32'hfa5, 1'b0, 12'h0, 32'h0);
    add_test("csr_unmapped", i_type(12'h7c0, 5'd1, 3'd1, 5'd23, OPC_SYS), 1'b1, 32'h0,
             32'h1234, 32'h0, 1'b0, 1'b0, 1'b0, 5'd23, 32'h0, 1'b1, 12'h7c0, 32'h1234);
    add_test("flush", i_type(12'h342, 5'd1, 3'd1, 5'd24, OPC_SYS), 1'b1, 32'h0, 32'h55,
             32'h0, 1'b0, 1'b1, 1'b1, 5'd24, 32'h0, 1'b0, 12'h0, 32'h0);
    // csrrsi with zero mask, no write
    add_test("unmapped_read", i_type(12'h7c0, 5'd0, 3'd6, 5'd25, OPC_SYS), 1'b1, 32'h0,
             32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 5'd25, 32'h0, 1'b0, 12'h0, 32'h0);
    add_test("flush_no_write", i_type(12'h342, 5'd1, 3'd2, 5'd26, OPC_SYS), 1'b1, 32'h0,
             32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 5'd26, 32'h0, 1'b0, 12'h0, 32'h0);
    // Unmapped write must not have reached the first scratch CSR
    add_test("base_read", i_type(12'h340, 5'd0, 3'd2, 5'd28, OPC_SYS), 1'b1, 32'h0, 32'h0,
             32'h0, 1'b0, 1'b0, 1'b0, 5'd28, 32'h3c, 1'b0, 12'h0, 32'h0);
    limit = tests.size() * 4 + 20;

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    assert (res.bubble == 1'b1 && csr_we_o == 1'b0) else begin
      $display("FAILED reset_state: expected bubble 1 we 0 actual bubble %0h we %0h",
               res.bubble, csr_we_o);
      reset_bad = 1'b1;
    end
    report("reset_state", reset_bad);

    // Two trailing steps drain the pipe
    for (i = 0; i < tests.size() + 2; i++) begin
      if (i >= 2) begin
        check_outputs(i - 2, i - 2, 1'b0);
        report(names[i-2], test_bad[i-2]);
      end
      if (i < tests.size() && tests[i].stall && i >= 2) begin
        apply_inputs(i, 1'b1);
        @(negedge clk_i);
        check_outputs(i - 2, i, 1'b1);
      end
      apply_inputs(i, 1'b0);
      @(negedge clk_i);
    end

    $display("%0d tests: %0d passed, %0d failed", passes + fails, passes, fails);
    if (fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  //////////////////////////////
  // Timeout
  //////////////////////////////

  always @(posedge clk_i) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule
